// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int word_width = 32;
	localparam int reg_addr_width = 5;

	// instruction field widths
	localparam int opcode_width = 6;
	localparam int funct_width = 6;
	localparam int shamt_width = 5;
	localparam int imm_width = 16;
	localparam int target_width = 26;

	typedef enum logic [opcode_width-1:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_JAL   = 6'b000011,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_t;

	typedef enum logic [funct_width-1:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_t;

	// jal and jalr link here
	localparam logic [reg_addr_width-1:0] link_reg = 5'd31;
	localparam logic [word_width-1:0] inst_nop = '0;

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef enum logic [3:0] {
		INIT,
		FETCH,
		INST_WAIT,
		DECODE,
		EXECUTE,
		MEM_LOAD,
		READ_WAIT,
		MEM_STORE,
		WRITEBACK
	} cpu_state_t;

	typedef enum logic [3:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {B_REG, B_SEXT_IMM, B_ZEXT_IMM, B_SHAMT} operand_b_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;
	typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_REG} next_pc_sel_t;

	localparam logic [isa_pkg::word_width-1:0] reset_pc = '0;

endpackage

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic                               clk,
	input  logic [isa_pkg::reg_addr_width-1:0] raddr1,
	input  logic [isa_pkg::reg_addr_width-1:0] raddr2,
	output logic [isa_pkg::word_width-1:0]     rdata1,
	output logic [isa_pkg::word_width-1:0]     rdata2,
	input  logic                               wen,
	input  logic [isa_pkg::reg_addr_width-1:0] waddr,
	input  logic [isa_pkg::word_width-1:0]     wdata
);
	import isa_pkg::*;

	logic [word_width-1:0] regs [0:(1<<reg_addr_width)-1];

	// $0 is never stored
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
	input  logic [isa_pkg::word_width-1:0]  a,
	input  logic [isa_pkg::word_width-1:0]  b,
	input  logic [isa_pkg::shamt_width-1:0] shamt,
	input  core_pkg::alu_op_t               op,
	output logic [isa_pkg::word_width-1:0]  result,
	output logic                            zero
);
	import isa_pkg::*;
	import core_pkg::*;

	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	always_comb begin
		case (op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLT:  result = {{(word_width-1){1'b0}}, signed_lt};
			ALU_SLTU: result = {{(word_width-1){1'b0}}, unsigned_lt};
			// shifts move b, the rt operand
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			ALU_SRA:  result = $signed(b) >>> shamt;
			ALU_LUI:  result = {b[imm_width-1:0], {imm_width{1'b0}}};
			default:  result = '0;
		endcase
	end

	// beq and bne test this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
`default_nettype none

module inst_decode (
	input  logic [isa_pkg::word_width-1:0]     instruction,
	output core_pkg::alu_op_t                  alu_op,
	output core_pkg::operand_b_sel_t           b_sel,
	output core_pkg::wb_sel_t                  wb_sel,
	output core_pkg::next_pc_sel_t             next_pc_sel,
	output logic                               reg_write,
	output logic [isa_pkg::reg_addr_width-1:0] dest_reg,
	output logic                               is_load,
	output logic                               is_store,
	output logic                               is_branch,
	output logic                               branch_on_equal,
	output logic                               is_nop
);
	import isa_pkg::*;
	import core_pkg::*;

	opcode_t opcode;
	funct_t funct;
	logic [reg_addr_width-1:0] rt;
	logic [reg_addr_width-1:0] rd;

	assign opcode = opcode_t'(instruction[word_width-1 -: opcode_width]);
	assign funct = funct_t'(instruction[funct_width-1:0]);
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign is_nop = (instruction == inst_nop);

	// alu operation
	always_comb begin
		alu_op = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_SRA:  alu_op = ALU_SRA;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_BEQ, OP_BNE: alu_op = ALU_SUB;
			OP_SLTI:  alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI:  alu_op = ALU_AND;
			OP_ORI:   alu_op = ALU_OR;
			OP_XORI:  alu_op = ALU_XOR;
			OP_LUI:   alu_op = ALU_LUI;
			default:  alu_op = ALU_ADD;
		endcase
	end

	// operand, write-back and next-pc selects plus class flags
	always_comb begin
		b_sel = B_REG;
		wb_sel = WB_ALU;
		next_pc_sel = NPC_SEQ;
		reg_write = 1'b0;
		dest_reg = rt;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		branch_on_equal = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dest_reg = rd;
				case (funct)
					FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
						reg_write = 1'b1;
					FN_SLL, FN_SRL, FN_SRA: begin
						b_sel = B_SHAMT;
						reg_write = 1'b1;
					end
					FN_JR: next_pc_sel = NPC_REG;
					FN_JALR: begin
						next_pc_sel = NPC_REG;
						wb_sel = WB_LINK;
						dest_reg = link_reg;
						reg_write = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				b_sel = B_SEXT_IMM;
				reg_write = 1'b1;
			end
			// logic immediates and lui take the raw 16 bits
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				b_sel = B_ZEXT_IMM;
				reg_write = 1'b1;
			end
			OP_LW: begin
				b_sel = B_SEXT_IMM;
				wb_sel = WB_LOAD;
				reg_write = 1'b1;
				is_load = 1'b1;
			end
			OP_SW: begin
				b_sel = B_SEXT_IMM;
				is_store = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				next_pc_sel = NPC_BRANCH;
				is_branch = 1'b1;
				branch_on_equal = (opcode == OP_BEQ);
			end
			OP_J: next_pc_sel = NPC_JUMP;
			OP_JAL: begin
				next_pc_sel = NPC_JUMP;
				wb_sel = WB_LINK;
				dest_reg = link_reg;
				reg_write = 1'b1;
			end
			default: reg_write = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== control_fsm.sv ====
`default_nettype none

module control_fsm (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inst_req_ready,
	input  logic                 inst_valid,
	input  logic                 mem_req_ready,
	input  logic                 read_data_valid,
	input  logic                 is_nop,
	input  logic                 is_load,
	input  logic                 is_store,
	input  logic                 reg_write,
	output core_pkg::cpu_state_t state,
	output logic                 inst_req_valid,
	output logic                 inst_ready,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 read_data_ready
);
	import core_pkg::*;

	cpu_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= INIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			INIT: next_state = FETCH;
			FETCH: begin
				if (inst_req_ready) next_state = INST_WAIT;
			end
			INST_WAIT: begin
				if (inst_valid) next_state = DECODE;
			end
			// a nop never reaches execute
			DECODE: next_state = is_nop ? FETCH : EXECUTE;
			EXECUTE: begin
				if (is_load) begin
					next_state = MEM_LOAD;
				end else if (is_store) begin
					next_state = MEM_STORE;
				end else if (reg_write) begin
					next_state = WRITEBACK;
				end else begin
					next_state = FETCH;
				end
			end
			MEM_LOAD: begin
				if (mem_req_ready) next_state = READ_WAIT;
			end
			READ_WAIT: begin
				if (read_data_valid) next_state = WRITEBACK;
			end
			MEM_STORE: begin
				if (mem_req_ready) next_state = FETCH;
			end
			WRITEBACK: next_state = FETCH;
			default: next_state = INIT;
		endcase
	end

	// handshake outputs come straight from the state
	assign inst_req_valid = (state == FETCH);
	assign inst_ready = (state == INST_WAIT);
	assign mem_read = (state == MEM_LOAD);
	assign mem_write = (state == MEM_STORE);
	assign read_data_ready = (state == READ_WAIT);

endmodule

`default_nettype wire

// ==== cpu_datapath.sv ====
`default_nettype none

module cpu_datapath (
	input  logic                                 clk,
	input  logic                                 rst,
	input  core_pkg::cpu_state_t                 state,
	input  logic [isa_pkg::word_width-1:0]       instruction,
	input  logic                                 inst_valid,
	input  logic [isa_pkg::word_width-1:0]       read_data,
	input  logic                                 read_data_valid,
	input  core_pkg::operand_b_sel_t             b_sel,
	input  core_pkg::wb_sel_t                    wb_sel,
	input  core_pkg::next_pc_sel_t               next_pc_sel,
	input  logic                                 reg_write,
	input  logic [isa_pkg::reg_addr_width-1:0]   dest_reg,
	input  logic                                 is_store,
	input  logic                                 is_branch,
	input  logic                                 branch_on_equal,
	input  logic                                 is_nop,
	input  logic [isa_pkg::word_width-1:0]       alu_result,
	input  logic                                 alu_zero,
	output logic [isa_pkg::word_width-1:0]       held_inst,
	output logic [isa_pkg::reg_addr_width-1:0]   rf_raddr1,
	output logic [isa_pkg::reg_addr_width-1:0]   rf_raddr2,
	input  logic [isa_pkg::word_width-1:0]       rdata1,
	input  logic [isa_pkg::word_width-1:0]       rdata2,
	output logic                                 rf_wen,
	output logic [isa_pkg::reg_addr_width-1:0]   rf_waddr,
	output logic [isa_pkg::word_width-1:0]       rf_wdata,
	output logic [isa_pkg::word_width-1:0]       alu_a,
	output logic [isa_pkg::word_width-1:0]       alu_b,
	output logic [isa_pkg::shamt_width-1:0]      shamt,
	output logic [isa_pkg::word_width-1:0]       pc,
	output logic [isa_pkg::word_width-1:0]       address,
	output logic [isa_pkg::word_width-1:0]       write_data,
	output logic [3:0]                           write_strb,
	output logic [isa_pkg::word_width-1:0]       cycle_count,
	output logic [isa_pkg::word_width-1:0]       inst_count,
	output logic [2*isa_pkg::word_width+isa_pkg::reg_addr_width:0] inst_retire
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [word_width-1:0] inst_pc;
	logic [word_width-1:0] rs_val;
	logic [word_width-1:0] rt_val;
	logic [word_width-1:0] result_reg;
	logic [word_width-1:0] load_reg;
	logic [word_width-1:0] seq_pc;
	logic [word_width-1:0] imm_sext;
	logic [word_width-1:0] imm_zext;
	logic [word_width-1:0] branch_target;
	logic [word_width-1:0] jump_target;
	logic [word_width-1:0] next_pc;
	logic [imm_width-1:0] imm;
	logic [target_width-1:0] target;
	logic branch_taken;

	assign rf_raddr1 = held_inst[25:21];
	assign rf_raddr2 = held_inst[20:16];
	assign imm = held_inst[imm_width-1:0];
	assign target = held_inst[target_width-1:0];
	assign imm_sext = {{(word_width-imm_width){imm[imm_width-1]}}, imm};
	assign imm_zext = {{(word_width-imm_width){1'b0}}, imm};

	always_ff @(posedge clk) begin
		// instruction and the address it came from
		if (state == INST_WAIT && inst_valid) begin
			held_inst <= instruction;
			inst_pc <= pc;
		end
		if (state == DECODE) begin
			rs_val <= rdata1;
			rt_val <= rdata2;
		end
		if (state == EXECUTE) begin
			result_reg <= alu_result;
		end
		if (state == READ_WAIT && read_data_valid) begin
			load_reg <= read_data;
		end
	end

	// register and shift forms both pass rt
	assign alu_a = rs_val;
	always_comb begin
		case (b_sel)
			B_SEXT_IMM: alu_b = imm_sext;
			B_ZEXT_IMM: alu_b = imm_zext;
			default:    alu_b = rt_val;
		endcase
	end
	assign shamt = (b_sel == B_SHAMT) ? held_inst[10:6] : '0;

	// no delay slot, so everything is relative to pc + 4
	assign seq_pc = inst_pc + word_width'(4);
	assign branch_target = seq_pc + {imm_sext[word_width-3:0], 2'b00};
	assign jump_target = {seq_pc[word_width-1:target_width+2], target, 2'b00};
	assign branch_taken = is_branch && (alu_zero == branch_on_equal);

	always_comb begin
		case (next_pc_sel)
			NPC_BRANCH: next_pc = branch_taken ? branch_target : seq_pc;
			NPC_JUMP:   next_pc = jump_target;
			NPC_REG:    next_pc = rs_val;
			default:    next_pc = seq_pc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (state == EXECUTE) begin
			pc <= next_pc;
		end else if (state == DECODE && is_nop) begin
			pc <= seq_pc;
		end
	end

	// word accesses only
	assign address = {result_reg[word_width-1:2], 2'b00};
	assign write_data = rt_val;
	assign write_strb = {4{is_store}};

	always_comb begin
		case (wb_sel)
			WB_LOAD: rf_wdata = load_reg;
			WB_LINK: rf_wdata = seq_pc;
			default: rf_wdata = result_reg;
		endcase
	end
	assign rf_wen = (state == WRITEBACK) && reg_write;
	assign rf_waddr = dest_reg;

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle_count <= '0;
			inst_count <= '0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			if (state == EXECUTE) inst_count <= inst_count + 1'b1;
		end
	end

	assign inst_retire = {rf_wen, rf_waddr, rf_wdata, inst_pc};

endmodule

`default_nettype wire

// ==== custom_cpu.sv ====
`default_nettype none

module custom_cpu (
	input  logic                               clk,
	input  logic                               rst,
	output logic [isa_pkg::word_width-1:0]     pc,
	output logic                               inst_req_valid,
	input  logic                               inst_req_ready,
	input  logic [isa_pkg::word_width-1:0]     instruction,
	input  logic                               inst_valid,
	output logic                               inst_ready,
	output logic [isa_pkg::word_width-1:0]     address,
	output logic                               mem_write,
	output logic [isa_pkg::word_width-1:0]     write_data,
	output logic [3:0]                         write_strb,
	output logic                               mem_read,
	input  logic                               mem_req_ready,
	input  logic [isa_pkg::word_width-1:0]     read_data,
	input  logic                               read_data_valid,
	output logic                               read_data_ready,
	output logic [isa_pkg::word_width-1:0]     cycle_count,
	output logic [isa_pkg::word_width-1:0]     inst_count,
	output logic [2*isa_pkg::word_width+isa_pkg::reg_addr_width:0] inst_retire
);
	import isa_pkg::*;
	import core_pkg::*;

	cpu_state_t state;
	alu_op_t alu_op;
	operand_b_sel_t b_sel;
	wb_sel_t wb_sel;
	next_pc_sel_t next_pc_sel;
	logic reg_write;
	logic [reg_addr_width-1:0] dest_reg;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic branch_on_equal;
	logic is_nop;
	logic [word_width-1:0] held_inst;
	logic [reg_addr_width-1:0] rf_raddr1;
	logic [reg_addr_width-1:0] rf_raddr2;
	logic [word_width-1:0] rdata1;
	logic [word_width-1:0] rdata2;
	logic rf_wen;
	logic [reg_addr_width-1:0] rf_waddr;
	logic [word_width-1:0] rf_wdata;
	logic [word_width-1:0] alu_a;
	logic [word_width-1:0] alu_b;
	logic [shamt_width-1:0] shamt;
	logic [word_width-1:0] alu_result;
	logic alu_zero;

	// decode looks at the held instruction, not the channel
	inst_decode u_decode (.*, .instruction(held_inst));

	control_fsm u_control (.*);

	cpu_datapath u_datapath (.*);

	reg_file u_reg_file (
		.clk,
		.raddr1(rf_raddr1),
		.raddr2(rf_raddr2),
		.rdata1,
		.rdata2,
		.wen(rf_wen),
		.waddr(rf_waddr),
		.wdata(rf_wdata)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.shamt,
		.op(alu_op),
		.result(alu_result),
		.zero(alu_zero)
	);

endmodule

`default_nettype wire

// ==== tb_custom_cpu.sv ====
`default_nettype none

module tb_custom_cpu;

	logic clk = 1'b0;
	logic rst;
	logic [31:0] pc;
	logic inst_req_valid;
	logic inst_req_ready;
	logic [31:0] instruction;
	logic inst_valid;
	logic inst_ready;
	logic [31:0] address;
	logic mem_write;
	logic [31:0] write_data;
	logic [3:0] write_strb;
	logic mem_read;
	logic mem_req_ready;
	logic [31:0] read_data;
	logic read_data_valid;
	logic read_data_ready;
	logic [31:0] cycle_count;
	logic [31:0] inst_count;
	logic [69:0] inst_retire;

	integer seed;
	logic [31:0] rnd;
	int errors;
	int checks;
	int prog_len;
	int tb_cycles;
	int tb_exec;
	logic [31:0] end_pc;
	logic done;
	logic timed_out;
	logic first_cycle;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] ref_dmem [0:255];
	logic [31:0] regs_ref [0:31];

	// reference model expectations for the instruction in flight
	logic exp_wen;
	logic [4:0] exp_waddr;
	logic [31:0] exp_wdata;
	logic [31:0] exp_pc;
	logic exp_load;
	logic exp_store;
	logic [31:0] exp_addr;
	logic [31:0] exp_sdata;
	logic [31:0] cur_ipc;

	// channel state of the memory model
	logic i_pending;
	logic [31:0] i_addr;
	logic rd_pending;
	logic [31:0] rd_addr;
	logic ireq_held;
	logic [31:0] held_pc;
	logic dreq_held;
	logic [69:0] held_dreq;

	logic [5:0] r_fn [0:10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
	logic [5:0] i_op [0:6] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	custom_cpu uut (.*);

	initial begin
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
		logic [25:0] tgt;
		tgt = 26'(idx);
		return {op, tgt};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		errors++;
		$display("[ERROR] t=%0t %s: got %h expected %h", $time, name, got, expected);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("[ERROR] t=%0t %s", $time, what);
	endtask

	// interpret one instruction against the reference registers
	task automatic predict(input logic [31:0] iw, input logic [31:0] ipc);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] pc4;
		op = iw[31:26];
		fn = iw[5:0];
		rs = iw[25:21];
		rt = iw[20:16];
		rd = iw[15:11];
		sh = iw[10:6];
		a = regs_ref[rs];
		b = regs_ref[rt];
		se = {{16{iw[15]}}, iw[15:0]};
		ze = {16'h0000, iw[15:0]};
		pc4 = ipc + 32'd4;
		exp_wen = 1'b0;
		exp_load = 1'b0;
		exp_store = 1'b0;
		exp_pc = pc4;
		exp_waddr = rt;
		if (iw != 32'h0) begin
			case (op)
				6'h00: begin
					exp_wen = 1'b1;
					exp_waddr = rd;
					case (fn)
						6'h21: exp_wdata = a + b;
						6'h23: exp_wdata = a - b;
						6'h24: exp_wdata = a & b;
						6'h25: exp_wdata = a | b;
						6'h26: exp_wdata = a ^ b;
						6'h27: exp_wdata = ~(a | b);
						6'h2a: exp_wdata = {31'h0, $signed(a) < $signed(b)};
						6'h2b: exp_wdata = {31'h0, a < b};
						6'h00: exp_wdata = b << sh;
						6'h02: exp_wdata = b >> sh;
						6'h03: exp_wdata = $signed(b) >>> sh;
						6'h08: begin
							exp_wen = 1'b0;
							exp_pc = a;
						end
						6'h09: begin
							exp_pc = a;
							exp_waddr = 5'd31;
							exp_wdata = pc4;
						end
						default: exp_wen = 1'b0;
					endcase
				end
				6'h02: exp_pc = {pc4[31:28], iw[25:0], 2'b00};
				6'h03: begin
					exp_pc = {pc4[31:28], iw[25:0], 2'b00};
					exp_wen = 1'b1;
					exp_waddr = 5'd31;
					exp_wdata = pc4;
				end
				6'h04: if (a == b) exp_pc = pc4 + {se[29:0], 2'b00};
				6'h05: if (a != b) exp_pc = pc4 + {se[29:0], 2'b00};
				6'h23: begin
					exp_load = 1'b1;
					exp_addr = a + se;
					exp_wen = 1'b1;
					exp_wdata = ref_dmem[exp_addr[9:2]];
				end
				6'h2b: begin
					exp_store = 1'b1;
					exp_addr = a + se;
					exp_sdata = b;
					ref_dmem[exp_addr[9:2]] = b;
				end
				default: begin
					exp_wen = 1'b1;
					case (op)
						6'h09: exp_wdata = a + se;
						6'h0a: exp_wdata = {31'h0, $signed(a) < $signed(se)};
						6'h0b: exp_wdata = {31'h0, a < se};
						6'h0c: exp_wdata = a & ze;
						6'h0d: exp_wdata = a | ze;
						6'h0e: exp_wdata = a ^ ze;
						6'h0f: exp_wdata = {iw[15:0], 16'h0000};
						default: exp_wen = 1'b0;
					endcase
				end
			endcase
		end
		// register 0 stays zero whatever retires to it
		if (exp_wen && exp_waddr != 5'd0) regs_ref[exp_waddr] = exp_wdata;
	endtask

	task automatic build_program();
		int k;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, 8'h3c};
			ref_dmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) regs_ref[i] = 32'h0;
		prog_len = 0;
		for (int r = 1; r <= 12; r++) begin
			rnd = $random(seed);
			emit(enc_i(6'h0f, 5'd0, 5'(r), rnd[31:16]));
			emit(enc_i(6'h0d, 5'(r), 5'(r), rnd[15:0]));
		end
		for (int n = 0; n < 20; n++) begin
			rnd = $random(seed);
			if (rnd[0]) begin
				emit(enc_r(5'(rnd[7:4] % 4'd13), 5'(rnd[27:24] % 4'd13),
					5'(rnd[23:20] % 4'd13), rnd[16:12], r_fn[rnd[11:8] % 4'd11]));
			end else begin
				emit(enc_i(i_op[rnd[11:8] % 4'd7], 5'(rnd[7:4] % 4'd13),
					5'(rnd[23:20] % 4'd13), rnd[31:16]));
			end
			if (n % 7 == 3) emit(32'h0);
		end
		// write to $0, the loads and stores below use it as their base
		emit(enc_i(6'h09, 5'd1, 5'd0, 16'h1234));
		for (int n = 0; n < 4; n++) begin
			rnd = $random(seed);
			emit(enc_i(6'h2b, 5'd0, 5'(rnd[3:0] % 4'd12 + 4'd1), 16'(16'h0200 + 4 * n)));
			emit(enc_i(6'h23, 5'd0, 5'(rnd[7:4] % 4'd12 + 4'd1), 16'(16'h0200 + 4 * n)));
		end
		// each branch skips one filler when taken
		emit(enc_i(6'h04, 5'd1, 5'd1, 16'h0001));
		emit(enc_i(6'h09, 5'd3, 5'd3, 16'h0011));
		emit(enc_i(6'h05, 5'd1, 5'd1, 16'h0001));
		emit(enc_i(6'h09, 5'd3, 5'd3, 16'h0022));
		emit(enc_i(6'h04, 5'd1, 5'd2, 16'h0001));
		emit(enc_i(6'h09, 5'd3, 5'd3, 16'h0033));
		emit(enc_i(6'h05, 5'd1, 5'd2, 16'h0001));
		emit(enc_i(6'h09, 5'd3, 5'd3, 16'h0044));
		k = prog_len;
		emit(enc_j(6'h02, k + 2));
		emit(enc_i(6'h09, 5'd5, 5'd5, 16'h0055));
		// jal into a short routine that returns through jr
		k = prog_len;
		emit(enc_j(6'h03, k + 3));
		emit(enc_j(6'h02, k + 5));
		emit(enc_i(6'h09, 5'd5, 5'd5, 16'h0066));
		emit(enc_i(6'h09, 5'd5, 5'd5, 16'h0001));
		emit(enc_r(5'd31, 5'd0, 5'd0, 5'd0, 6'h08));
		k = prog_len;
		emit(enc_i(6'h09, 5'd0, 5'd20, 16'((k + 3) * 4)));
		emit(enc_r(5'd20, 5'd0, 5'd31, 5'd0, 6'h09));
		emit(enc_i(6'h09, 5'd6, 5'd6, 16'h0007));
		emit(32'h0);
		end_pc = 32'(prog_len * 4);
		emit(enc_j(6'h02, prog_len));
	endtask

	// memory model responses, random stalls
	always @(negedge clk) begin
		rnd = $random(seed);
		inst_req_ready <= (inst_req_valid === 1'b1) && rnd[1:0] != 2'b00;
		inst_valid <= i_pending && rnd[3:2] != 2'b00;
		instruction <= imem[i_addr[9:2]];
		mem_req_ready <= (mem_read === 1'b1 || mem_write === 1'b1) && rnd[5:4] != 2'b00;
		read_data_valid <= rd_pending && rnd[7:6] != 2'b00;
		read_data <= dmem[rd_addr[9:2]];
	end

	always @(posedge clk) begin
		if (rst) begin
			first_cycle = 1'b1;
			tb_cycles = 0;
		end else begin
			if (first_cycle) begin
				checks++;
				assert (!inst_req_valid && !inst_ready && !mem_read && !mem_write &&
					!read_data_ready)
				else report_failure("handshake output high in the first cycle after reset");
				first_cycle = 1'b0;
			end
			// requests must hold still while stalled
			if (ireq_held) begin
				assert (inst_req_valid) else report_failure("inst_req_valid dropped early");
				assert (pc == held_pc) else report_mismatch("pc (stalled)", pc, held_pc);
			end
			if (dreq_held) begin
				assert ({mem_read, mem_write, write_strb, address, write_data} == held_dreq)
				else report_failure("data request changed before mem_req_ready");
			end
			ireq_held = inst_req_valid && !inst_req_ready;
			held_pc = pc;
			dreq_held = (mem_read || mem_write) && !mem_req_ready;
			held_dreq = {mem_read, mem_write, write_strb, address, write_data};

			if (inst_req_valid && inst_req_ready && !done) begin
				checks++;
				assert (pc == exp_pc) else report_mismatch("pc", pc, exp_pc);
				assert (!exp_wen && !exp_load && !exp_store)
				else report_failure("previous instruction ended without its write or access");
				if (pc == end_pc) begin
					assert (inst_count == 32'(tb_exec))
					else report_mismatch("inst_count", inst_count, 32'(tb_exec));
					assert (cycle_count == 32'(tb_cycles))
					else report_mismatch("cycle_count", cycle_count, 32'(tb_cycles));
					done = 1'b1;
				end else begin
					i_pending = 1'b1;
					i_addr = pc;
				end
			end
			if (inst_valid && inst_ready) begin
				i_pending = 1'b0;
				cur_ipc = i_addr;
				if (imem[i_addr[9:2]] != 32'h0) tb_exec++;
				predict(imem[i_addr[9:2]], i_addr);
			end

			if (mem_req_ready && (mem_read || mem_write)) begin
				checks++;
				assert (address == exp_addr) else report_mismatch("address", address, exp_addr);
				if (mem_write) begin
					assert (exp_store) else report_failure("unexpected store request");
					assert (write_data == exp_sdata)
					else report_mismatch("write_data", write_data, exp_sdata);
					assert (write_strb == 4'hf)
					else report_mismatch("write_strb", 32'(write_strb), 32'hf);
					dmem[address[9:2]] = write_data;
					exp_store = 1'b0;
				end else begin
					assert (exp_load) else report_failure("unexpected load request");
					rd_pending = 1'b1;
					rd_addr = address;
					exp_load = 1'b0;
				end
			end
			if (read_data_valid && read_data_ready) rd_pending = 1'b0;

			if (inst_retire[69]) begin
				checks++;
				assert (exp_wen) else report_failure("register write retired unexpectedly");
				assert (inst_retire[68:64] == exp_waddr)
				else report_mismatch("retire waddr", 32'(inst_retire[68:64]), 32'(exp_waddr));
				assert (inst_retire[63:32] == exp_wdata)
				else report_mismatch("retire wdata", inst_retire[63:32], exp_wdata);
				assert (inst_retire[31:0] == cur_ipc)
				else report_mismatch("retire pc", inst_retire[31:0], cur_ipc);
				exp_wen = 1'b0;
			end
			tb_cycles++;
		end
	end

	initial begin
		seed = 32'h09f0_d65c;
		errors = 0;
		checks = 0;
		tb_exec = 0;
		done = 1'b0;
		timed_out = 1'b0;
		i_pending = 1'b0;
		i_addr = 32'h0;
		rd_pending = 1'b0;
		rd_addr = 32'h0;
		ireq_held = 1'b0;
		dreq_held = 1'b0;
		exp_wen = 1'b0;
		exp_load = 1'b0;
		exp_store = 1'b0;
		exp_pc = 32'h0;
		cur_ipc = 32'h0;
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = 32'h0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = 32'h0;
		read_data_valid = 1'b0;
		build_program();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fork
			wait (done);
			begin
				repeat (prog_len * 40) @(posedge clk);
				timed_out = 1'b1;
			end
		join_any
		disable fork;
		if (timed_out) $display("timeout: the program did not reach its end address");
		$display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
		if (timed_out || errors != 0) begin
			$display("** FAIL **");
		end else begin
			$display("** PASS **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== custom_cpu.f ====
isa_pkg.sv
core_pkg.sv
reg_file.sv
alu.sv
inst_decode.sv
control_fsm.sv
cpu_datapath.sv
custom_cpu.sv
tb_custom_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_custom_cpu \
	-f custom_cpu.f -o tb_custom_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/tb_custom_cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q -x -F '** PASS **' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
